// File: sim.f
RvPkg.sv
RegisterFile.sv
StageIF.sv
StageID.sv
StageEX.sv
StageMEM.sv
ProcessorPP.sv
tb_ProcessorPP.sv

// File: tb_ProcessorPP.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ProcessorPP
    import RvPkg::*;
();

    localparam int PROG_LEN    = 200;
    localparam int DMEM_WORDS  = 256;
    localparam int CYCLE_LIMIT = 2 * PROG_LEN + 40;

    // Instruction kinds of the random program
    localparam int KIND_ADD  = 0,
                   KIND_SUB  = 1,
                   KIND_AND  = 2,
                   KIND_OR   = 3,
                   KIND_XOR  = 4,
                   KIND_SLT  = 5,
                   KIND_ADDI = 6,
                   KIND_ANDI = 7,
                   KIND_ORI  = 8,
                   KIND_XORI = 9,
                   KIND_SLTI = 10,
                   KIND_LW   = 11,
                   KIND_SW   = 12;

    logic              clock;
    logic              rstN;
    logic [ADDR_W-1:0] instAddr;
    logic [DATA_W-1:0] inst;
    logic [ADDR_W-1:0] dataAddr;
    logic              dataWrEnable;
    logic [DATA_W-1:0] dataWrData;
    logic [DATA_W-1:0] dataRdData;
    logic              wbEnable;
    logic [REG_AW-1:0] wbAddr;
    logic [DATA_W-1:0] wbData;

    int                progKind [PROG_LEN];
    logic [REG_AW-1:0] progRd   [PROG_LEN];
    logic [REG_AW-1:0] progRs1  [PROG_LEN];
    logic [REG_AW-1:0] progRs2  [PROG_LEN];
    logic [DATA_W-1:0] progImm  [PROG_LEN];  // Sign-extended
    logic [DATA_W-1:0] progMem  [PROG_LEN];
    logic [DATA_W-1:0] dataMem  [DMEM_WORDS];

    logic [REG_AW-1:0] wbAddrQ [$];  // Expected register writes in order
    logic [DATA_W-1:0] wbDataQ [$];
    logic [ADDR_W-1:0] stAddrQ [$];  // Expected stores in order
    logic [DATA_W-1:0] stDataQ [$];

    int          cycleCount = 0;

    ProcessorPP
    i_dut (
        .i_clock        (clock),
        .i_rstN         (rstN),
        .o_instAddr     (instAddr),
        .i_inst         (inst),
        .o_dataAddr     (dataAddr),
        .o_dataWrEnable (dataWrEnable),
        .o_dataWrData   (dataWrData),
        .i_dataRdData   (dataRdData),
        .o_wbEnable     (wbEnable),
        .o_wbAddr       (wbAddr),
        .o_wbData       (wbData));

    // --------------------------------------------------
    // Memory models
    // --------------------------------------------------

    assign inst = (instAddr < ADDR_W'(PROG_LEN * 4)) ? progMem[instAddr[9:2]] : NOP_INST;
    assign dataRdData = dataMem[dataAddr[9:2]];  // Combinational read

    always @(posedge clock) begin
        if (dataWrEnable)
            dataMem[dataAddr[9:2]] <= dataWrData;
    end

    // --------------------------------------------------
    // Program generation and reference model
    // --------------------------------------------------

    function automatic logic [DATA_W-1:0] encodeInst(int kind, logic [REG_AW-1:0] rd,
            logic [REG_AW-1:0] rs1, logic [REG_AW-1:0] rs2, logic [11:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = 7'b0;
        case (kind)
            KIND_ADD, KIND_ADDI: f3 = F3_ADD;
            KIND_SUB: begin
                f3 = F3_ADD;
                f7 = F7_SUB;
            end
            KIND_AND, KIND_ANDI: f3 = F3_AND;
            KIND_OR, KIND_ORI:   f3 = F3_OR;
            KIND_XOR, KIND_XORI: f3 = F3_XOR;
            KIND_SLT, KIND_SLTI: f3 = F3_SLT;
            default:             f3 = F3_LW;
        endcase
        if (kind <= KIND_SLT)
            return {f7, rs2, rs1, f3, rd, OPC_OP};
        else if (kind <= KIND_SLTI)
            return {imm, rs1, f3, rd, OPC_OPIMM};
        else if (kind == KIND_LW)
            return {imm, rs1, f3, rd, OPC_LOAD};
        else
            return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic void buildProgram();
        int          kind;
        logic [11:0] imm12;
        for (int i = 0; i < DMEM_WORDS; i++)
            dataMem[i] = $urandom();
        for (int n = 0; n < PROG_LEN; n++) begin
            kind       = $urandom_range(0, KIND_SW);
            imm12      = 12'($urandom());
            progRd[n]  = REG_AW'($urandom_range(0, 7));  // Few registers, many hazards
            progRs1[n] = REG_AW'($urandom_range(0, 7));
            progRs2[n] = REG_AW'($urandom_range(0, 7));
            if (kind == KIND_LW || kind == KIND_SW) begin
                progRs1[n] = '0;  // Absolute word address
                imm12      = 12'(4 * $urandom_range(0, DMEM_WORDS - 1));
            end
            progKind[n] = kind;
            progImm[n]  = {{(DATA_W-12){imm12[11]}}, imm12};
            progMem[n]  = encodeInst(kind, progRd[n], progRs1[n], progRs2[n], imm12);
        end
    endfunction

    function automatic logic [DATA_W-1:0] computeAlu(int kind, logic [DATA_W-1:0] a,
            logic [DATA_W-1:0] b);
        case (kind)
            KIND_SUB:            return a - b;
            KIND_AND, KIND_ANDI: return a & b;
            KIND_OR, KIND_ORI:   return a | b;
            KIND_XOR, KIND_XORI: return a ^ b;
            KIND_SLT, KIND_SLTI: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:             return a + b;
        endcase
    endfunction

    // Runs the program in order on a private copy of the data memory
    function automatic void executeProgram();
        logic [DATA_W-1:0] regs [32];
        logic [DATA_W-1:0] mem  [DMEM_WORDS];
        logic [DATA_W-1:0] a, b, result;
        logic [ADDR_W-1:0] addr;
        int                kind;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            mem[i] = dataMem[i];
        for (int n = 0; n < PROG_LEN; n++) begin
            kind = progKind[n];
            a    = regs[progRs1[n]];
            b    = regs[progRs2[n]];
            addr = a + progImm[n];
            if (kind == KIND_SW) begin
                mem[addr[9:2]] = b;
                stAddrQ.push_back(addr);
                stDataQ.push_back(b);
            end else begin
                if (kind == KIND_LW)
                    result = mem[addr[9:2]];
                else if (kind <= KIND_SLT)
                    result = computeAlu(kind, a, b);
                else
                    result = computeAlu(kind, a, progImm[n]);
                if (progRd[n] != '0) begin  // x0 stays zero, no trace
                    regs[progRd[n]] = result;
                    wbAddrQ.push_back(progRd[n]);
                    wbDataQ.push_back(result);
                end
            end
        end
    endfunction

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------

    task automatic abortRun();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic checkWriteBack();
        logic [REG_AW-1:0] expAddr;
        logic [DATA_W-1:0] expData;
        assert (wbAddrQ.size() > 0) else begin
            $display("Register write to x%0d at %0t ns after all expected writes were seen",
                     wbAddr, $time);
            abortRun();
        end
        expAddr = wbAddrQ.pop_front();
        expData = wbDataQ.pop_front();
        assert (wbAddr === expAddr && wbData === expData) else begin
            $display("[ERROR] %0t ns: write-back x%0d = %h, expected x%0d = %h",
                     $time, wbAddr, wbData, expAddr, expData);
            abortRun();
        end
    endtask

    task automatic checkStore();
        logic [ADDR_W-1:0] expAddr;
        logic [DATA_W-1:0] expData;
        assert (stAddrQ.size() > 0) else begin
            $display("Store to address %h at %0t ns after all expected stores were seen",
                     dataAddr, $time);
            abortRun();
        end
        expAddr = stAddrQ.pop_front();
        expData = stDataQ.pop_front();
        assert (dataAddr === expAddr && dataWrData === expData) else begin
            $display("[ERROR] %0t ns: store [%h] = %h, expected [%h] = %h",
                     $time, dataAddr, dataWrData, expAddr, expData);
            abortRun();
        end
    endtask

    // Mid-cycle sampling, outputs settled
    always @(negedge clock) begin
        if (rstN) begin
            assert (!$isunknown({wbEnable, dataWrEnable})) else begin
                $display("Write-back or store enable is undefined at %0t ns", $time);
                abortRun();
            end
            if (wbEnable)
                checkWriteBack();
            if (dataWrEnable)
                checkStore();
        end
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        assert (cycleCount < CYCLE_LIMIT) else begin
            $display("Timeout after %0d cycles with expected events still missing",
                     CYCLE_LIMIT);
            abortRun();
        end
    end

    // --------------------------------------------------
    // Clock, reset and run control
    // --------------------------------------------------

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        rstN = 1'b0;
        void'($urandom(59880));
        buildProgram();
        executeProgram();
        repeat (2) @(posedge clock);
        #1 rstN = 1'b1;
        while (wbAddrQ.size() != 0 || stAddrQ.size() != 0)
            @(negedge clock);
        repeat (8) @(negedge clock);  // Trailing NOPs must stay quiet
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: ProcessorPP.sv
`timescale 1ns/1ps
`default_nettype none

module ProcessorPP
    import RvPkg::*;
(
    input  wire logic              i_clock,         // Clock
    input  wire logic              i_rstN,          // Reset
    output logic      [ADDR_W-1:0] o_instAddr,      // Instruction memory
    input  wire logic [DATA_W-1:0] i_inst,
    output logic      [ADDR_W-1:0] o_dataAddr,      // Data memory
    output logic                   o_dataWrEnable,
    output logic      [DATA_W-1:0] o_dataWrData,
    input  wire logic [DATA_W-1:0] i_dataRdData,
    output logic                   o_wbEnable,      // Write-back trace
    output logic      [REG_AW-1:0] o_wbAddr,
    output logic      [DATA_W-1:0] o_wbData);

    // --------------------------------------------------
    // Stage IF
    // --------------------------------------------------

    logic              ID_stall;
    logic [DATA_W-1:0] IFID_inst;
    logic [ADDR_W-1:0] IFID_pc;

    StageIF
    stageIF (
        .i_clock    (i_clock),
        .i_rstN     (i_rstN),
        .i_stall    (ID_stall),
        .i_inst     (i_inst),
        .o_instAddr (o_instAddr),
        .o_inst     (IFID_inst),
        .o_pc       (IFID_pc));

    // --------------------------------------------------
    // Stage ID
    // --------------------------------------------------

    logic [DATA_W-1:0]   IDEX_dataA, IDEX_dataB, IDEX_imm;
    logic                IDEX_useImm;
    logic [ALU_OP_W-1:0] IDEX_aluOp;
    logic [REG_AW-1:0]   IDEX_regWrAddr;
    logic                IDEX_regWrEnable, IDEX_isLoad, IDEX_memWrEnable;
    logic [DATA_W-1:0]   EX_result;
    logic [REG_AW-1:0]   EXMEM_regWrAddr;
    logic                EXMEM_regWrEnable;
    logic [DATA_W-1:0]   MEM_regWrData;

    StageID
    stageID (
        .i_clock       (i_clock),
        .i_rstN        (i_rstN),
        .i_inst        (IFID_inst),
        .i_pc          (IFID_pc),
        .i_exWrAddr    (IDEX_regWrAddr),    // Forward from EX
        .i_exWrEnable  (IDEX_regWrEnable),
        .i_exIsLoad    (IDEX_isLoad),
        .i_exResult    (EX_result),
        .i_memWrAddr   (EXMEM_regWrAddr),   // Forward from MEM
        .i_memWrEnable (EXMEM_regWrEnable),
        .i_memWrData   (MEM_regWrData),
        .i_wbWrAddr    (o_wbAddr),          // Write-back, also the trace
        .i_wbWrEnable  (o_wbEnable),
        .i_wbWrData    (o_wbData),
        .o_stall       (ID_stall),
        .o_dataA       (IDEX_dataA),
        .o_dataB       (IDEX_dataB),
        .o_imm         (IDEX_imm),
        .o_useImm      (IDEX_useImm),
        .o_aluOp       (IDEX_aluOp),
        .o_regWrAddr   (IDEX_regWrAddr),
        .o_regWrEnable (IDEX_regWrEnable),
        .o_isLoad      (IDEX_isLoad),
        .o_memWrEnable (IDEX_memWrEnable));

    // --------------------------------------------------
    // Stage EX
    // --------------------------------------------------

    logic [DATA_W-1:0] EXMEM_result, EXMEM_storeData;
    logic              EXMEM_isLoad, EXMEM_memWrEnable;

    StageEX
    stageEX (
        .i_clock       (i_clock),
        .i_rstN        (i_rstN),
        .i_dataA       (IDEX_dataA),
        .i_dataB       (IDEX_dataB),
        .i_imm         (IDEX_imm),
        .i_useImm      (IDEX_useImm),
        .i_aluOp       (IDEX_aluOp),
        .i_regWrAddr   (IDEX_regWrAddr),
        .i_regWrEnable (IDEX_regWrEnable),
        .i_isLoad      (IDEX_isLoad),
        .i_memWrEnable (IDEX_memWrEnable),
        .o_exResult    (EX_result),
        .o_result      (EXMEM_result),
        .o_storeData   (EXMEM_storeData),
        .o_regWrAddr   (EXMEM_regWrAddr),
        .o_regWrEnable (EXMEM_regWrEnable),
        .o_isLoad      (EXMEM_isLoad),
        .o_memWrEnable (EXMEM_memWrEnable));

    // --------------------------------------------------
    // Stage MEM, write-back registers inside
    // --------------------------------------------------

    StageMEM
    stageMEM (
        .i_clock        (i_clock),
        .i_rstN         (i_rstN),
        .i_result       (EXMEM_result),
        .i_storeData    (EXMEM_storeData),
        .i_regWrAddr    (EXMEM_regWrAddr),
        .i_regWrEnable  (EXMEM_regWrEnable),
        .i_isLoad       (EXMEM_isLoad),
        .i_memWrEnable  (EXMEM_memWrEnable),
        .i_dataRdData   (i_dataRdData),
        .o_dataAddr     (o_dataAddr),
        .o_dataWrEnable (o_dataWrEnable),
        .o_dataWrData   (o_dataWrData),
        .o_memWrData    (MEM_regWrData),
        .o_wbEnable     (o_wbEnable),
        .o_wbAddr       (o_wbAddr),
        .o_wbData       (o_wbData));

endmodule

`default_nettype wire

// File: StageMEM.sv
`timescale 1ns/1ps
`default_nettype none

module StageMEM
    import RvPkg::*;
(
    input  wire logic              i_clock,         // Clock
    input  wire logic              i_rstN,          // Reset
    input  wire logic [DATA_W-1:0] i_result,        // ALU result or address
    input  wire logic [DATA_W-1:0] i_storeData,
    input  wire logic [REG_AW-1:0] i_regWrAddr,
    input  wire logic              i_regWrEnable,
    input  wire logic              i_isLoad,
    input  wire logic              i_memWrEnable,
    input  wire logic [DATA_W-1:0] i_dataRdData,    // Combinational read
    output logic      [ADDR_W-1:0] o_dataAddr,
    output logic                   o_dataWrEnable,
    output logic      [DATA_W-1:0] o_dataWrData,
    output logic      [DATA_W-1:0] o_memWrData,     // For forwarding
    output logic                   o_wbEnable,      // MEM/WB register
    output logic      [REG_AW-1:0] o_wbAddr,
    output logic      [DATA_W-1:0] o_wbData);

    assign o_dataAddr     = i_result;
    assign o_dataWrEnable = i_memWrEnable;
    assign o_dataWrData   = i_storeData;

    assign o_memWrData = i_isLoad ? i_dataRdData : i_result;

    // --------------------------------------------------
    // MEM/WB register
    // --------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rstN)
            o_wbEnable <= 1'b0;
        else
            o_wbEnable <= i_regWrEnable;
    end

    always_ff @(posedge i_clock) begin
        o_wbAddr <= i_regWrAddr;
        o_wbData <= o_memWrData;
    end

    // Decode sets at most one of these per instruction
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        !(i_memWrEnable && i_isLoad));

endmodule

`default_nettype wire

// File: StageEX.sv
`timescale 1ns/1ps
`default_nettype none

module StageEX
    import RvPkg::*;
(
    input  wire logic                i_clock,        // Clock
    input  wire logic                i_rstN,         // Reset
    input  wire logic [DATA_W-1:0]   i_dataA,
    input  wire logic [DATA_W-1:0]   i_dataB,
    input  wire logic [DATA_W-1:0]   i_imm,
    input  wire logic                i_useImm,       // Immediate as operand B
    input  wire logic [ALU_OP_W-1:0] i_aluOp,
    input  wire logic [REG_AW-1:0]   i_regWrAddr,
    input  wire logic                i_regWrEnable,
    input  wire logic                i_isLoad,
    input  wire logic                i_memWrEnable,
    output logic      [DATA_W-1:0]   o_exResult,     // For forwarding
    output logic      [DATA_W-1:0]   o_result,       // EX/MEM register
    output logic      [DATA_W-1:0]   o_storeData,
    output logic      [REG_AW-1:0]   o_regWrAddr,
    output logic                     o_regWrEnable,
    output logic                     o_isLoad,
    output logic                     o_memWrEnable);

    logic [DATA_W-1:0] opB;

    assign opB = i_useImm ? i_imm : i_dataB;

    always_comb begin
        case (i_aluOp)
            ALU_ADD: o_exResult = i_dataA + opB;
            ALU_SUB: o_exResult = i_dataA - opB;
            ALU_AND: o_exResult = i_dataA & opB;
            ALU_OR:  o_exResult = i_dataA | opB;
            ALU_XOR: o_exResult = i_dataA ^ opB;
            ALU_SLT: o_exResult = DATA_W'($signed(i_dataA) < $signed(opB));
            default: o_exResult = '0;
        endcase
    end

    // --------------------------------------------------
    // EX/MEM register
    // --------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rstN) begin
            o_regWrEnable <= 1'b0;
            o_isLoad      <= 1'b0;
            o_memWrEnable <= 1'b0;
        end else begin
            o_regWrEnable <= i_regWrEnable;
            o_isLoad      <= i_isLoad;
            o_memWrEnable <= i_memWrEnable;
        end
    end

    always_ff @(posedge i_clock) begin
        o_result    <= o_exResult;
        o_storeData <= i_dataB;  // Forwarded rs2
        o_regWrAddr <= i_regWrAddr;
    end

endmodule

`default_nettype wire

// File: StageID.sv
`timescale 1ns/1ps
`default_nettype none

module StageID
    import RvPkg::*;
(
    input  wire logic                i_clock,        // Clock
    input  wire logic                i_rstN,         // Reset
    input  wire logic [DATA_W-1:0]   i_inst,         // IF/ID instruction
    input  wire logic [ADDR_W-1:0]   i_pc,           // IF/ID address
    input  wire logic [REG_AW-1:0]   i_exWrAddr,     // Instruction in EX
    input  wire logic                i_exWrEnable,
    input  wire logic                i_exIsLoad,
    input  wire logic [DATA_W-1:0]   i_exResult,
    input  wire logic [REG_AW-1:0]   i_memWrAddr,    // Instruction in MEM
    input  wire logic                i_memWrEnable,
    input  wire logic [DATA_W-1:0]   i_memWrData,
    input  wire logic [REG_AW-1:0]   i_wbWrAddr,     // Write-back this cycle
    input  wire logic                i_wbWrEnable,
    input  wire logic [DATA_W-1:0]   i_wbWrData,
    output logic                     o_stall,        // Load-use bubble
    output logic      [DATA_W-1:0]   o_dataA,
    output logic      [DATA_W-1:0]   o_dataB,
    output logic      [DATA_W-1:0]   o_imm,
    output logic                     o_useImm,
    output logic      [ALU_OP_W-1:0] o_aluOp,
    output logic      [REG_AW-1:0]   o_regWrAddr,
    output logic                     o_regWrEnable,
    output logic                     o_isLoad,
    output logic                     o_memWrEnable);

    InstWord             inst;
    logic                isOp, isOpImm, isLoad, isStore;
    logic [REG_AW-1:0]   rs1, rs2, rd;
    logic                useRs1, useRs2;
    logic [ALU_OP_W-1:0] aluOp;
    logic [DATA_W-1:0]   imm;
    logic                regWrEnable;
    logic [DATA_W-1:0]   rfDataA, rfDataB;
    logic [DATA_W-1:0]   dataA, dataB;

    // --------------------------------------------------
    // Decode
    // --------------------------------------------------

    assign inst    = i_inst;
    assign isOp    = inst.rFmt.opcode == OPC_OP;
    assign isOpImm = inst.iFmt.opcode == OPC_OPIMM;
    assign isLoad  = inst.iFmt.opcode == OPC_LOAD && inst.iFmt.funct3 == F3_LW;
    assign isStore = inst.sFmt.opcode == OPC_STORE && inst.sFmt.funct3 == F3_LW;

    assign rs1    = inst.rFmt.rs1;
    assign rs2    = inst.rFmt.rs2;
    assign rd     = inst.rFmt.rd;
    assign useRs1 = isOp || isOpImm || isLoad || isStore;
    assign useRs2 = isOp || isStore;

    assign regWrEnable = (isOp || isOpImm || isLoad) && rd != '0;

    // Sign-extended I or S immediate
    assign imm = isStore ? {{(DATA_W-12){inst.sFmt.immHi[6]}}, inst.sFmt.immHi, inst.sFmt.immLo}
                         : {{(DATA_W-12){inst.iFmt.imm12[11]}}, inst.iFmt.imm12};

    always_comb begin
        aluOp = ALU_ADD;  // Address calculation too
        if (isOp || isOpImm) begin
            case (inst.rFmt.funct3)
                F3_ADD:  aluOp = (isOp && inst.rFmt.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                F3_SLT:  aluOp = ALU_SLT;
                F3_XOR:  aluOp = ALU_XOR;
                F3_OR:   aluOp = ALU_OR;
                F3_AND:  aluOp = ALU_AND;
                default: aluOp = ALU_ADD;
            endcase
        end
    end

    RegisterFile
    registerFile (
        .i_clock    (i_clock),
        .i_rstN     (i_rstN),
        .i_rdAddrA  (rs1),
        .i_rdAddrB  (rs2),
        .o_rdDataA  (rfDataA),
        .o_rdDataB  (rfDataB),
        .i_wrEnable (i_wbWrEnable),
        .i_wrAddr   (i_wbWrAddr),
        .i_wrData   (i_wbWrData));

    // --------------------------------------------------
    // Forwarding and load-use hazard
    // --------------------------------------------------

    // EX first, then MEM, then WB, then the register file
    always_comb begin
        if (i_exWrEnable && !i_exIsLoad && i_exWrAddr == rs1)
            dataA = i_exResult;
        else if (i_memWrEnable && i_memWrAddr == rs1)
            dataA = i_memWrData;
        else if (i_wbWrEnable && i_wbWrAddr == rs1)
            dataA = i_wbWrData;
        else
            dataA = rfDataA;
    end

    always_comb begin
        if (i_exWrEnable && !i_exIsLoad && i_exWrAddr == rs2)
            dataB = i_exResult;
        else if (i_memWrEnable && i_memWrAddr == rs2)
            dataB = i_memWrData;
        else if (i_wbWrEnable && i_wbWrAddr == rs2)
            dataB = i_wbWrData;
        else
            dataB = rfDataB;
    end

    // Load result not ready until MEM
    assign o_stall = i_exIsLoad && i_exWrEnable &&
                     ((useRs1 && i_exWrAddr == rs1) || (useRs2 && i_exWrAddr == rs2));

    // --------------------------------------------------
    // ID/EX register
    // --------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rstN || o_stall) begin
            o_regWrEnable <= 1'b0;  // Bubble
            o_isLoad      <= 1'b0;
            o_memWrEnable <= 1'b0;
        end else begin
            o_regWrEnable <= regWrEnable;
            o_isLoad      <= isLoad;
            o_memWrEnable <= isStore;
        end
    end

    always_ff @(posedge i_clock) begin
        o_dataA     <= dataA;
        o_dataB     <= dataB;
        o_imm       <= imm;
        o_useImm    <= !isOp;
        o_aluOp     <= aluOp;
        o_regWrAddr <= rd;
    end

    // A bubble clears the load from EX, so the stall lasts one cycle
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        o_stall |=> !o_stall);

    // Fetch holds the same word while decode stalls
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        o_stall |=> (i_pc == $past(i_pc) && i_inst == $past(i_inst)));

endmodule

`default_nettype wire

// File: StageIF.sv
`timescale 1ns/1ps
`default_nettype none

module StageIF
    import RvPkg::*;
(
    input  wire logic              i_clock,     // Clock
    input  wire logic              i_rstN,      // Reset
    input  wire logic              i_stall,     // Load-use stall from decode
    input  wire logic [DATA_W-1:0] i_inst,      // Word from instruction memory
    output logic      [ADDR_W-1:0] o_instAddr,  // Current PC
    output logic      [DATA_W-1:0] o_inst,      // IF/ID instruction
    output logic      [ADDR_W-1:0] o_pc);       // IF/ID address

    logic [ADDR_W-1:0] pc;

    assign o_instAddr = pc;

    always_ff @(posedge i_clock) begin
        if (!i_rstN) begin
            pc     <= '0;
            o_inst <= NOP_INST;  // Decode sees a NOP after reset
        end else if (!i_stall) begin
            pc     <= pc + ADDR_W'(4);  // No branches, always sequential
            o_inst <= i_inst;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_stall)
            o_pc <= pc;
    end

endmodule

`default_nettype wire

// File: RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegisterFile
    import RvPkg::*;
(
    input  wire logic              i_clock,     // Clock
    input  wire logic              i_rstN,      // Reset
    input  wire logic [REG_AW-1:0] i_rdAddrA,
    input  wire logic [REG_AW-1:0] i_rdAddrB,
    output logic      [DATA_W-1:0] o_rdDataA,
    output logic      [DATA_W-1:0] o_rdDataB,
    input  wire logic              i_wrEnable,  // Write port from write-back
    input  wire logic [REG_AW-1:0] i_wrAddr,
    input  wire logic [DATA_W-1:0] i_wrData);

    logic [DATA_W-1:0] regs [2**REG_AW];

    always_ff @(posedge i_clock) begin
        if (!i_rstN) begin
            for (int i = 0; i < 2**REG_AW; i++)
                regs[i] <= '0;
        end else if (i_wrEnable && i_wrAddr != '0) begin
            regs[i_wrAddr] <= i_wrData;  // x0 never written
        end
    end

    // Write-through so a same-cycle write is seen by the read
    assign o_rdDataA = (i_wrEnable && i_rdAddrA != '0 && i_wrAddr == i_rdAddrA) ?
                       i_wrData : regs[i_rdAddrA];
    assign o_rdDataB = (i_wrEnable && i_rdAddrB != '0 && i_wrAddr == i_rdAddrB) ?
                       i_wrData : regs[i_rdAddrB];

    // Decode drops the enable for rd = x0 before the write reaches here
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        i_wrEnable |-> i_wrAddr != '0);

endmodule

`default_nettype wire

// File: RvPkg.sv
`default_nettype none

package RvPkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------

    localparam int DATA_W   = 32;  // Data word
    localparam int ADDR_W   = 32;  // Byte address
    localparam int REG_AW   = 5;   // Register index
    localparam int ALU_OP_W = 3;

    // ALU operation codes
    localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;

    // --------------------------------------------------
    // RV32I encodings of the supported subset
    // --------------------------------------------------

    localparam logic [6:0] OPC_OP    = 7'b0110011;  // Register-register
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;  // Register-immediate
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    localparam logic [2:0] F3_ADD = 3'b000;  // Also SUB
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_LW  = 3'b010;  // Word load and store

    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam logic [DATA_W-1:0] NOP_INST = 32'h0000_0013;  // ADDI x0, x0, 0

    // One fetched word, seen through the format its opcode selects
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rFmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iFmt;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sFmt;
    } InstWord;

endpackage

`default_nettype wire
